// File: hw/gpio_pkg.sv
`default_nettype none

package gpio_pkg;

  localparam int unsigned NUM_GPIO  = 32;
  localparam int unsigned PIN_IDX_W = 5;

  // register offsets
  localparam logic [11:0] REG_SETGPIO = 12'h000;
  localparam logic [11:0] REG_CLRGPIO = 12'h004;
  localparam logic [11:0] REG_TOGGPIO = 12'h008;
  localparam logic [11:0] REG_PIN0    = 12'h010;
  localparam logic [11:0] REG_PIN1    = 12'h014;
  localparam logic [11:0] REG_PIN2    = 12'h018;
  localparam logic [11:0] REG_PIN3    = 12'h01C;
  localparam logic [11:0] REG_OUT0    = 12'h020;
  localparam logic [11:0] REG_OUT1    = 12'h024;
  localparam logic [11:0] REG_OUT2    = 12'h028;
  localparam logic [11:0] REG_OUT3    = 12'h02C;
  localparam logic [11:0] REG_SETSEL  = 12'h030;
  localparam logic [11:0] REG_RDSTAT  = 12'h034;
  localparam logic [11:0] REG_SETDIR  = 12'h038;
  localparam logic [11:0] REG_SETINT  = 12'h03C;

  // field positions, shared by writes and RDSTAT
  localparam int unsigned DIR_LSB     = 24;
  localparam int unsigned INTTYPE_LSB = 17;
  localparam int unsigned INTEN_BIT   = 16;
  localparam int unsigned IN_BIT      = 12;
  localparam int unsigned OUT_BIT     = 8;

  typedef logic [NUM_GPIO-1:0]  gpio_vec_t;
  typedef logic [PIN_IDX_W-1:0] pin_idx_t;
  typedef logic [11:0]          apb_addr_t;
  typedef logic [31:0]          apb_data_t;
  typedef logic [1:0]           dir_mode_t;   // [0] output enable, [1] open drain
  typedef logic [2:0]           irq_type_t;   // [0] fall, [1] rise, [2] level high

  typedef struct packed {
    apb_addr_t paddr;
    apb_data_t pwdata;
    logic      pwrite;
    logic      psel;
    logic      penable;
  } apb_req_t;

  typedef struct packed {
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
  } apb_rsp_t;

  typedef struct packed {
    gpio_vec_t level;
    gpio_vec_t rise;
    gpio_vec_t fall;
  } pin_state_t;

  typedef struct packed {
    gpio_vec_t                  inten;
    irq_type_t [NUM_GPIO-1:0]   inttype;
  } irq_cfg_t;

endpackage

`default_nettype wire

// File: hw/gpio_in_sync.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_in_sync (
  input  logic                 HCLK,
  input  logic                 HRESETn,
  input  gpio_pkg::gpio_vec_t  gpio_in,
  output gpio_pkg::pin_state_t pins
);

  import gpio_pkg::*;

  gpio_vec_t  sync0_q;   // first stage, may go metastable
  gpio_vec_t  sync1_q;
  pin_state_t state_q;

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      sync0_q <= '0;
      sync1_q <= '0;
    end else begin
      sync0_q <= gpio_in;
      sync1_q <= sync0_q;
    end
  end

  // held level plus edge pulses, all updated on the same edge
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state_q <= '0;
    end else begin
      state_q.level <= sync1_q;
      state_q.rise  <= sync1_q & ~state_q.level;   // low to high
      state_q.fall  <= ~sync1_q & state_q.level;   // high to low
    end
  end

  // pulses line up with the first cycle of the new level
  assign pins = state_q;

endmodule

`default_nettype wire

// File: hw/gpio_irq_detect.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_irq_detect (
  input  gpio_pkg::pin_state_t pins,
  input  gpio_pkg::irq_cfg_t   cfg,
  output gpio_pkg::gpio_vec_t  interrupt
);

  import gpio_pkg::*;

  gpio_vec_t edge_hit;
  gpio_vec_t level_hit;
  irq_type_t pin_type;

  always_comb begin
    edge_hit  = '0;
    level_hit = '0;
    pin_type  = '0;
    for (int i = 0; i < NUM_GPIO; i++) begin
      pin_type = cfg.inttype[i];
      edge_hit[i] = (pin_type[0] & pins.fall[i]) |   // falling edge
                    (pin_type[1] & pins.rise[i]);    // rising edge
      // level mode only when no edge bit is set
      if (pin_type[1:0] == 2'b00) begin
        level_hit[i] = ~(pins.level[i] ^ pin_type[2]);
      end
    end
  end

  assign interrupt = cfg.inten & (edge_hit | level_hit);

endmodule

`default_nettype wire

// File: hw/gpio_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_apb_regs (
  input  logic                 HCLK,
  input  logic                 HRESETn,
  input  gpio_pkg::apb_req_t   req,
  output gpio_pkg::apb_rsp_t   rsp,
  input  gpio_pkg::pin_state_t pins,
  output gpio_pkg::irq_cfg_t   cfg,
  output gpio_pkg::gpio_vec_t  gpio_out,
  output gpio_pkg::gpio_vec_t  gpio_dir
);

  import gpio_pkg::*;

  gpio_vec_t                 out_q;
  dir_mode_t [NUM_GPIO-1:0]  dir_q;
  irq_cfg_t                  cfg_q;
  pin_idx_t                  sel_q;

  logic      access;
  logic      wr_en;
  logic      rd_ok;
  logic      wr_ok;
  pin_idx_t  wr_idx;
  apb_data_t rd_data;
  apb_data_t stat_word;

  assign access = req.psel & req.penable;
  assign wr_idx = pin_idx_t'(req.pwdata[PIN_IDX_W-1:0]);

  // status word for the selected pin
  always_comb begin
    stat_word = '0;
    stat_word[DIR_LSB +: $bits(dir_mode_t)]     = dir_q[sel_q];
    stat_word[INTTYPE_LSB +: $bits(irq_type_t)] = cfg_q.inttype[sel_q];
    stat_word[INTEN_BIT]                        = cfg_q.inten[sel_q];
    stat_word[IN_BIT]                           = pins.level[sel_q];
    stat_word[OUT_BIT]                          = out_q[sel_q];
    stat_word[PIN_IDX_W-1:0]                    = sel_q;
  end

  // address decode and read mux
  always_comb begin
    rd_data = '0;
    rd_ok   = 1'b0;
    wr_ok   = 1'b0;
    case (req.paddr)
      REG_SETGPIO, REG_CLRGPIO, REG_TOGGPIO: begin
        wr_ok = 1'b1;
      end
      REG_SETSEL, REG_SETDIR, REG_SETINT: begin
        wr_ok = 1'b1;
      end
      REG_OUT0: begin
        wr_ok   = 1'b1;
        rd_ok   = 1'b1;
        rd_data = out_q;
      end
      REG_OUT1, REG_OUT2, REG_OUT3: begin   // no pins behind these
        wr_ok = 1'b1;
        rd_ok = 1'b1;
      end
      REG_PIN0: begin
        rd_ok   = 1'b1;
        rd_data = pins.level;
      end
      REG_PIN1, REG_PIN2, REG_PIN3: begin
        rd_ok = 1'b1;
      end
      REG_RDSTAT: begin
        rd_ok   = 1'b1;
        rd_data = stat_word;
      end
      default: begin
        rd_ok = 1'b0;   // unmapped
        wr_ok = 1'b0;
      end
    endcase
  end

  assign wr_en = access & req.pwrite & wr_ok;

  always_comb begin
    rsp.pready  = 1'b1;   // zero wait states
    rsp.prdata  = '0;
    rsp.pslverr = 1'b0;
    if (access) begin
      if (req.pwrite) begin
        rsp.pslverr = ~wr_ok;
      end else begin
        rsp.pslverr = ~rd_ok;
        rsp.prdata  = rd_data;   // zero unless the read maps
      end
    end
  end

  // configuration registers
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      out_q <= '0;
      dir_q <= '0;
      cfg_q <= '0;
      sel_q <= '0;
    end else if (wr_en) begin
      case (req.paddr)
        REG_SETGPIO: begin
          out_q[wr_idx] <= 1'b1;
          sel_q         <= wr_idx;
        end
        REG_CLRGPIO: begin
          out_q[wr_idx] <= 1'b0;
          sel_q         <= wr_idx;
        end
        REG_TOGGPIO: begin
          out_q[wr_idx] <= ~out_q[wr_idx];
          sel_q         <= wr_idx;
        end
        REG_OUT0: begin
          out_q <= req.pwdata;
        end
        REG_SETSEL: begin
          sel_q <= wr_idx;
        end
        REG_SETDIR: begin
          dir_q[wr_idx] <= req.pwdata[DIR_LSB +: $bits(dir_mode_t)];
          sel_q         <= wr_idx;
        end
        REG_SETINT: begin
          cfg_q.inttype[wr_idx] <= req.pwdata[INTTYPE_LSB +: $bits(irq_type_t)];
          cfg_q.inten[wr_idx]   <= req.pwdata[INTEN_BIT];
          sel_q                 <= wr_idx;
        end
        default: begin
          sel_q <= sel_q;   // OUT1-OUT3 writes store nothing
        end
      endcase
    end
  end

  assign cfg = cfg_q;

  // pad drive
  always_comb begin
    gpio_out = '0;
    gpio_dir = '0;
    for (int i = 0; i < NUM_GPIO; i++) begin
      gpio_out[i] = out_q[i] & dir_q[i][0];
      // open drain drives only the low level
      gpio_dir[i] = dir_q[i][1] ? ~out_q[i] : dir_q[i][0];
    end
  end

endmodule

`default_nettype wire

// File: hw/gpio_top.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_top (
  input  logic                HCLK,
  input  logic                HRESETn,
  input  gpio_pkg::apb_addr_t PADDR,
  input  gpio_pkg::apb_data_t PWDATA,
  input  logic                PWRITE,
  input  logic                PSEL,
  input  logic                PENABLE,
  output gpio_pkg::apb_data_t PRDATA,
  output logic                PREADY,
  output logic                PSLVERR,
  input  gpio_pkg::gpio_vec_t gpio_in,
  output gpio_pkg::gpio_vec_t gpio_in_sync,
  output gpio_pkg::gpio_vec_t gpio_out,
  output gpio_pkg::gpio_vec_t gpio_dir,
  output gpio_pkg::gpio_vec_t interrupt
);

  import gpio_pkg::*;

  apb_req_t   apb_req;
  apb_rsp_t   apb_rsp;
  pin_state_t pin_state;
  irq_cfg_t   irq_cfg;

  assign apb_req.paddr   = PADDR;
  assign apb_req.pwdata  = PWDATA;
  assign apb_req.pwrite  = PWRITE;
  assign apb_req.psel    = PSEL;
  assign apb_req.penable = PENABLE;

  assign PRDATA  = apb_rsp.prdata;
  assign PREADY  = apb_rsp.pready;
  assign PSLVERR = apb_rsp.pslverr;

  assign gpio_in_sync = pin_state.level;   // filtered level

  gpio_in_sync u_in_sync (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .gpio_in (gpio_in),
    .pins    (pin_state)
  );

  gpio_irq_detect u_irq_detect (
    .pins      (pin_state),
    .cfg       (irq_cfg),
    .interrupt (interrupt)
  );

  gpio_apb_regs u_apb_regs (
    .HCLK     (HCLK),
    .HRESETn  (HRESETn),
    .req      (apb_req),
    .rsp      (apb_rsp),
    .pins     (pin_state),
    .cfg      (irq_cfg),
    .gpio_out (gpio_out),
    .gpio_dir (gpio_dir)
  );

endmodule

`default_nettype wire

// File: tb/gpio_properties.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_properties (
  input logic                HCLK,
  input logic                HRESETn,
  input logic                PSEL,
  input logic                PENABLE,
  input logic                PREADY,
  input logic                PSLVERR,
  input gpio_pkg::apb_data_t PRDATA,
  input gpio_pkg::gpio_vec_t gpio_out,
  input gpio_pkg::gpio_vec_t gpio_dir,
  input gpio_pkg::gpio_vec_t interrupt
);

  int unsigned fail_cnt = 0;   // assertion failures so far

  // no wait states ever
  ap_pready_high : assert property (
    @(posedge HCLK) disable iff (!HRESETn) PREADY == 1'b1
  ) else begin
    fail_cnt++;
    $error("PREADY dropped low");
  end

  // response is quiet outside the access phase
  ap_idle_quiet : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    !(PSEL && PENABLE) |-> (PRDATA == '0 && PSLVERR == 1'b0)
  ) else begin
    fail_cnt++;
    $error("PRDATA or PSLVERR active outside the access phase");
  end

  // first cycle out of reset
  ap_reset_outputs : assert property (
    @(posedge HCLK) $rose(HRESETn) |->
      (interrupt == '0 && gpio_out == '0 && gpio_dir == '0)
  ) else begin
    fail_cnt++;
    $error("pin outputs not cleared after reset");
  end

endmodule

bind gpio_top gpio_properties u_props (.*);

`default_nettype wire

// File: tb/gpio_tb.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_tb;

  import gpio_pkg::*;

  localparam int XFER       = 3;   // setup, access, idle
  localparam int N_OUT_OPS  = 16;
  localparam int N_DIR_PINS = 4;
  localparam int N_IN_PATS  = 12;
  localparam int N_IRQ_CYC  = 48;
  localparam int T_RESET    = 4 + 2 * XFER;
  localparam int T_OUT      = N_OUT_OPS * 3 * XFER + 16 * XFER;
  localparam int T_DIR      = 4 * N_DIR_PINS * 5 * XFER;
  localparam int T_IN       = N_IN_PATS + N_IN_PATS * (1 + XFER);
  localparam int T_IRQ      = 14 * XFER + N_IRQ_CYC;
  localparam int T_ERR      = 7 * XFER + 4;
  localparam int TIMEOUT_CYC = 2 * (T_RESET + T_OUT + T_DIR + T_IN + T_IRQ + T_ERR);

  logic      HCLK;
  logic      HRESETn;
  apb_addr_t PADDR;
  apb_data_t PWDATA;
  logic      PWRITE;
  logic      PSEL;
  logic      PENABLE;
  apb_data_t PRDATA;
  logic      PREADY;
  logic      PSLVERR;
  gpio_vec_t gpio_in;
  gpio_vec_t in_sync;
  gpio_vec_t gpio_out;
  gpio_vec_t gpio_dir;
  gpio_vec_t interrupt;

  logic [15:0] lfsr_q;
  int          err_count = 0;
  int          cycle_cnt = 0;

  // shadow of the configuration and the pin history
  gpio_vec_t sh_out;
  gpio_vec_t sh_en;
  dir_mode_t sh_dir [NUM_GPIO];
  irq_type_t sh_type [NUM_GPIO];
  pin_idx_t  sh_sel;
  gpio_vec_t hist [1:4];   // gpio_in at the last four edges

  gpio_top UUT (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .PADDR        (PADDR),
    .PWDATA       (PWDATA),
    .PWRITE       (PWRITE),
    .PSEL         (PSEL),
    .PENABLE      (PENABLE),
    .PRDATA       (PRDATA),
    .PREADY       (PREADY),
    .PSLVERR      (PSLVERR),
    .gpio_in      (gpio_in),
    .gpio_in_sync (in_sync),
    .gpio_out     (gpio_out),
    .gpio_dir     (gpio_dir),
    .interrupt    (interrupt)
  );

  initial begin
    HCLK = 1'b0;
    forever #2 HCLK = ~HCLK;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      r      = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  function automatic apb_data_t irq_word(input pin_idx_t idx, input irq_type_t t, input logic en);
    apb_data_t w;
    w = '0;
    w[INTTYPE_LSB +: 3] = t;
    w[INTEN_BIT]        = en;
    w[PIN_IDX_W-1:0]    = idx;
    return w;
  endfunction

  function automatic logic exp_err(input apb_addr_t addr, input logic wr);
    logic wr_map;
    logic rd_map;
    wr_map = 1'b0;
    rd_map = 1'b0;
    case (addr)
      REG_SETGPIO, REG_CLRGPIO, REG_TOGGPIO, REG_SETSEL, REG_SETDIR, REG_SETINT: wr_map = 1'b1;
      REG_OUT0, REG_OUT1, REG_OUT2, REG_OUT3: begin
        wr_map = 1'b1;
        rd_map = 1'b1;
      end
      REG_PIN0, REG_PIN1, REG_PIN2, REG_PIN3, REG_RDSTAT: rd_map = 1'b1;
      default: wr_map = 1'b0;
    endcase
    return wr ? !wr_map : !rd_map;
  endfunction

  function automatic apb_data_t exp_read(input apb_addr_t addr);
    apb_data_t w;
    w = '0;
    case (addr)
      REG_OUT0: w = sh_out;
      REG_PIN0: w = hist[3];
      REG_RDSTAT: begin
        w[DIR_LSB +: 2]     = sh_dir[sh_sel];
        w[INTTYPE_LSB +: 3] = sh_type[sh_sel];
        w[INTEN_BIT]        = sh_en[sh_sel];
        w[IN_BIT]           = hist[3][sh_sel];
        w[OUT_BIT]          = sh_out[sh_sel];
        w[PIN_IDX_W-1:0]    = sh_sel;
      end
      default: w = '0;
    endcase
    return w;
  endfunction

  function automatic gpio_vec_t exp_pad_out();
    gpio_vec_t v;
    v = '0;
    for (int i = 0; i < NUM_GPIO; i++) begin
      case (sh_dir[i])
        2'b01, 2'b11: v[i] = sh_out[i];   // output enabled
        default:      v[i] = 1'b0;
      endcase
    end
    return v;
  endfunction

  function automatic gpio_vec_t exp_pad_dir();
    gpio_vec_t v;
    v = '0;
    for (int i = 0; i < NUM_GPIO; i++) begin
      case (sh_dir[i])
        2'b00:   v[i] = 1'b0;         // input only
        2'b01:   v[i] = 1'b1;         // push-pull
        default: v[i] = !sh_out[i];   // open drain pulls low only
      endcase
    end
    return v;
  endfunction

  function automatic gpio_vec_t exp_irq();
    gpio_vec_t v;
    gpio_vec_t rise;
    gpio_vec_t fall;
    rise = hist[3] & ~hist[4];
    fall = ~hist[3] & hist[4];
    for (int i = 0; i < NUM_GPIO; i++) begin
      if (sh_type[i][1:0] == 2'b00) begin
        v[i] = (hist[3][i] == sh_type[i][2]);
      end else begin
        v[i] = (sh_type[i][0] & fall[i]) | (sh_type[i][1] & rise[i]);
      end
    end
    return v & sh_en;
  endfunction

  task automatic check_data(input string name, input apb_data_t got, input apb_data_t exp);
    if (got !== exp) begin
      err_count++;
      $display("FAILED %s expected %h got %h", name, exp, got);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  task automatic check_vec(input string name, input gpio_vec_t got, input gpio_vec_t exp);
    if (got !== exp) begin
      err_count++;
      $display("FAILED %s expected %h got %h", name, exp, got);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  task automatic check_err(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      err_count++;
      $display("FAILED %s expected %h got %h", name, exp, got);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  task automatic apply_write(input apb_addr_t addr, input apb_data_t data);
    pin_idx_t idx;
    idx = data[PIN_IDX_W-1:0];
    case (addr)
      REG_SETGPIO: sh_out[idx] = 1'b1;
      REG_CLRGPIO: sh_out[idx] = 1'b0;
      REG_TOGGPIO: sh_out[idx] = ~sh_out[idx];
      REG_OUT0:    sh_out = data;
      REG_SETDIR:  sh_dir[idx] = data[DIR_LSB +: 2];
      REG_SETINT: begin
        sh_type[idx] = data[INTTYPE_LSB +: 3];
        sh_en[idx]   = data[INTEN_BIT];
      end
      default: sh_sel = sh_sel;
    endcase
    if (addr inside {REG_SETGPIO, REG_CLRGPIO, REG_TOGGPIO,
                     REG_SETSEL, REG_SETDIR, REG_SETINT}) begin
      sh_sel = idx;
    end
  endtask

  // checks use the pre-edge values before the model advances
  always @(posedge HCLK) begin
    if (UUT.u_props.fail_cnt != 0) begin
      $display("A bound assertion on the APB response or the pin outputs failed");
      $display("Test failures found");
      $fatal(1);
    end
    if (!HRESETn) begin
      sh_out = '0;
      sh_en  = '0;
      sh_sel = '0;
      for (int i = 0; i < NUM_GPIO; i++) begin
        sh_dir[i]  = '0;
        sh_type[i] = '0;
      end
      for (int i = 1; i <= 4; i++) begin
        hist[i] = '0;
      end
    end else begin
      check_err("PREADY", PREADY, 1'b1);
      if (PSEL && PENABLE) begin
        check_err("PSLVERR", PSLVERR, exp_err(PADDR, PWRITE));
        if (!PWRITE) begin
          check_data("PRDATA", PRDATA, exp_read(PADDR));
        end
      end else begin
        check_err("PSLVERR", PSLVERR, 1'b0);
        check_data("PRDATA", PRDATA, '0);
      end
      check_vec("gpio_in_sync", in_sync, hist[3]);
      check_vec("gpio_out", gpio_out, exp_pad_out());
      check_vec("gpio_dir", gpio_dir, exp_pad_dir());
      check_vec("interrupt", interrupt, exp_irq());
      if (PSEL && PENABLE && PWRITE && PREADY && !exp_err(PADDR, 1'b1)) begin
        apply_write(PADDR, PWDATA);
      end
      hist[4] = hist[3];
      hist[3] = hist[2];
      hist[2] = hist[1];
      hist[1] = gpio_in;
    end
  end

  always @(posedge HCLK) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYC) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("Test failures found");
      $fatal(1);
    end
  end

  task automatic apb_xfer(input apb_addr_t addr, input apb_data_t data, input logic wr);
    @(negedge HCLK);
    PSEL    = 1'b1;
    PENABLE = 1'b0;
    PWRITE  = wr;
    PADDR   = addr;
    PWDATA  = wr ? data : '0;
    @(negedge HCLK);
    PENABLE = 1'b1;
    do @(posedge HCLK); while (!PREADY);
    @(negedge HCLK);
    PSEL    = 1'b0;
    PENABLE = 1'b0;
    PWRITE  = 1'b0;
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
    apb_xfer(addr, data, 1'b1);
  endtask

  task automatic apb_read(input apb_addr_t addr);
    apb_xfer(addr, '0, 1'b0);
  endtask

  initial begin
    pin_idx_t  idx;
    apb_addr_t op_addr;
    HRESETn = 1'b0;
    PADDR   = '0;
    PWDATA  = '0;
    PWRITE  = 1'b0;
    PSEL    = 1'b0;
    PENABLE = 1'b0;
    gpio_in = '0;
    lfsr_q  = 16'd17;
    repeat (2) @(posedge HCLK);
    @(negedge HCLK);
    HRESETn = 1'b1;

    apb_read(REG_OUT0);
    apb_read(REG_RDSTAT);

    // single-bit writes on random pins with noise in the upper data bits
    for (int k = 0; k < N_OUT_OPS; k++) begin
      idx     = pin_idx_t'(rand_bits(PIN_IDX_W));
      op_addr = (k % 3 == 0) ? REG_SETGPIO : (k % 3 == 1) ? REG_CLRGPIO : REG_TOGGPIO;
      apb_write(op_addr, (apb_data_t'(rand_bits(27)) << PIN_IDX_W) | apb_data_t'(idx));
      apb_read(REG_RDSTAT);
      apb_read(REG_OUT0);
    end
    repeat (4) begin
      apb_write(REG_OUT0, rand_bits(32));
      apb_read(REG_OUT0);
      apb_write(REG_SETSEL, rand_bits(PIN_IDX_W));
      apb_read(REG_RDSTAT);
    end

    for (int m = 0; m < 4; m++) begin
      for (int k = 0; k < N_DIR_PINS; k++) begin
        idx = pin_idx_t'(rand_bits(PIN_IDX_W));
        apb_write(REG_SETDIR, (apb_data_t'(m) << DIR_LSB) | apb_data_t'(idx));
        apb_write(REG_SETGPIO, apb_data_t'(idx));
        apb_read(REG_RDSTAT);
        apb_write(REG_CLRGPIO, apb_data_t'(idx));
        apb_read(REG_RDSTAT);
      end
    end

    // random inputs while no interrupt is enabled
    repeat (N_IN_PATS) begin
      @(negedge HCLK);
      gpio_in = rand_bits(32);
    end
    repeat (N_IN_PATS) begin
      @(negedge HCLK);
      gpio_in = rand_bits(32);
      apb_read(REG_PIN0);
    end

    apb_write(REG_SETINT, irq_word(5'd0, 3'b001, 1'b1));   // fall
    apb_write(REG_SETINT, irq_word(5'd1, 3'b010, 1'b1));   // rise
    apb_write(REG_SETINT, irq_word(5'd2, 3'b011, 1'b1));   // both
    apb_write(REG_SETINT, irq_word(5'd3, 3'b100, 1'b1));   // level high
    apb_write(REG_SETINT, irq_word(5'd4, 3'b000, 1'b1));   // level low
    apb_write(REG_SETINT, irq_word(5'd5, 3'b010, 1'b0));
    repeat (8) begin
      idx = pin_idx_t'(rand_bits(PIN_IDX_W));
      apb_write(REG_SETINT, irq_word(idx, irq_type_t'(rand_bits(3)), 1'(rand_bits(1))));
    end
    repeat (N_IRQ_CYC) begin
      @(negedge HCLK);
      gpio_in = rand_bits(32);
    end

    apb_write(12'h0FC, rand_bits(32));
    apb_write(REG_PIN0, rand_bits(32));
    apb_write(REG_RDSTAT, rand_bits(32));
    apb_read(REG_SETDIR);
    apb_read(12'h100);
    apb_read(REG_OUT0);
    apb_read(REG_RDSTAT);
    repeat (4) @(negedge HCLK);

    if (err_count == 0 && UUT.u_props.fail_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: gpio_sub.f
hw/gpio_pkg.sv
hw/gpio_in_sync.sv
hw/gpio_irq_detect.sv
hw/gpio_apb_regs.sv
hw/gpio_top.sv
tb/gpio_properties.sv
tb/gpio_tb.sv
